/* design/reg_block_defs.svh */
`ifndef REG_BLOCK_DEFS_SVH
`define REG_BLOCK_DEFS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define REG_DATA_W       64
`define REG_SEL_W        8
`define REG_ADDR_W       13

// Block base, 32 words, hit on address bits 12:5
`define REG_BASE_ADDR    13'h1000

// --------------------------------------------------
// Word offsets inside the block
// --------------------------------------------------
`define ADDR_CORE_PN     5'h2
`define ADDR_CORE_C      5'h3
`define ADDR_REM_PN      5'h4
`define ADDR_REM_C       5'h5
`define ADDR_INT_SET     5'h8
`define ADDR_INT_STATUS  5'hA
`define ADDR_SCRATCH_LO  5'h10
`define ADDR_SCRATCH_HI  5'h11

// Scratch-pad reset values
`define SCRATCH0_RST     32'h0000_0000
`define SCRATCH1_RST     32'h1111_1111
`define SCRATCH2_RST     32'h2222_2222
`define SCRATCH3_RST     32'h3333_3333

`endif

/* design/wb_bus_pkg.sv */
`default_nettype none

`include "reg_block_defs.svh"

package wb_bus_pkg;

    // --------------------------------------------------
    // Wishbone classic request, master to slave
    // --------------------------------------------------
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`REG_ADDR_W-1:0]   adr;
        logic [`REG_SEL_W-1:0]    sel;
        logic [`REG_DATA_W-1:0]   dat;
    } wb_req_t;

    // --------------------------------------------------
    // Wishbone classic response, slave to master
    // --------------------------------------------------
    typedef struct packed {
        logic                     ack;
        // Read data, zero for writes
        logic [`REG_DATA_W-1:0]   dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* design/reg_map_pkg.sv */
`default_nettype none

package reg_map_pkg;

    // --------------------------------------------------
    // Flow-control credits
    // --------------------------------------------------
    typedef struct packed {
        logic [7:0]  hdr;
        logic [11:0] data;
    } credit_t;

    // One side of the link
    typedef struct packed {
        credit_t p;
        credit_t np;
        credit_t cpl;
    } credit_set_t;

    // Readback layout of one credit type
    typedef struct packed {
        logic [3:0]  rsvd_hi;
        logic [11:0] data;
        logic [7:0]  rsvd_lo;
        logic [7:0]  hdr;
    } credit_dword_t;

    // --------------------------------------------------
    // Read word, credit view or plain dword view
    // --------------------------------------------------
    typedef union packed {
        struct packed {
            credit_dword_t upper;
            credit_dword_t lower;
        } credit;
        struct packed {
            logic [31:0] upper;
            logic [31:0] lower;
        } dword;
    } rd_word_u;

    // Byte-lane write enables per register
    typedef struct packed {
        logic [3:0] int_set;
        logic [3:0] int_clr;
        logic [7:0] scratch_lo;
        logic [7:0] scratch_hi;
    } wr_strobe_t;

    // One-hot read select
    typedef struct packed {
        logic core_pn;
        logic core_c;
        logic rem_pn;
        logic rem_c;
        logic int_status;
        logic scratch_lo;
        logic scratch_hi;
    } rd_sel_t;

endpackage

`default_nettype wire

/* design/reg_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "reg_block_defs.svh"

module reg_decode
    import wb_bus_pkg::*;
    import reg_map_pkg::*;
(
    input  wire logic       reg_clk,
    input  wire logic       reg_rst_n,
    input  wire wb_req_t    wb_req,
    output logic            ack,
    output wr_strobe_t      wr_strobe,
    output rd_sel_t         rd_sel
);

    localparam logic [`REG_ADDR_W-1:0] BASE_ADDR = `REG_BASE_ADDR;

    logic       hit;
    logic       access;
    logic       wr_access;
    logic       rd_access;
    logic [4:0] word;

    // --------------------------------------------------
    // Access qualification
    // --------------------------------------------------

    // Block hit on the upper address bits
    assign hit    = (wb_req.adr[`REG_ADDR_W-1:5] == BASE_ADDR[`REG_ADDR_W-1:5]);
    assign word   = wb_req.adr[4:0];

    // Not ack so a held request strobes only once
    assign access    = wb_req.cyc & wb_req.stb & ~ack;
    assign wr_access = access & wb_req.we & hit;
    assign rd_access = access & ~wb_req.we & hit;

    // --------------------------------------------------
    // Write strobes and read select
    // --------------------------------------------------
    always_comb
    begin
        wr_strobe = '0;
        rd_sel    = '0;

        if (wr_access)
        begin
            case (word)
                // Interrupt words use the lower dword only
                `ADDR_INT_SET:    wr_strobe.int_set    = wb_req.sel[3:0];
                `ADDR_INT_STATUS: wr_strobe.int_clr    = wb_req.sel[3:0];
                `ADDR_SCRATCH_LO: wr_strobe.scratch_lo = wb_req.sel;
                `ADDR_SCRATCH_HI: wr_strobe.scratch_hi = wb_req.sel;
                default:          wr_strobe            = '0;
            endcase
        end

        if (rd_access)
        begin
            case (word)
                `ADDR_CORE_PN:    rd_sel.core_pn    = 1'b1;
                `ADDR_CORE_C:     rd_sel.core_c     = 1'b1;
                `ADDR_REM_PN:     rd_sel.rem_pn     = 1'b1;
                `ADDR_REM_C:      rd_sel.rem_c      = 1'b1;
                `ADDR_INT_STATUS: rd_sel.int_status = 1'b1;
                `ADDR_SCRATCH_LO: rd_sel.scratch_lo = 1'b1;
                `ADDR_SCRATCH_HI: rd_sel.scratch_hi = 1'b1;
                // Write-only and unmapped words read zero
                default:          rd_sel            = '0;
            endcase
        end
    end

    // --------------------------------------------------
    // Acknowledge
    // --------------------------------------------------

    // Every access is acked, in range or not
    always_ff @(posedge reg_clk or negedge reg_rst_n)
    begin
        if (!reg_rst_n)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= access;
        end
    end

endmodule

`default_nettype wire

/* design/reg_execute.sv */
`timescale 1ns/1ns
`default_nettype none

`include "reg_block_defs.svh"

module reg_execute
    import reg_map_pkg::*;
(
    input  wire logic                   reg_clk,
    input  wire logic                   reg_rst_n,
    input  wire wr_strobe_t             wr_strobe,
    input  wire logic [`REG_DATA_W-1:0] wr_data,
    input  wire credit_set_t            core_credits,
    input  wire credit_set_t            rem_credits,
    input  wire logic                   msi_en,
    input  wire logic                   msix_en,
    output logic [31:0]                 mgmt_interrupt,
    output logic [31:0]                 int_status,
    output logic [3:0][31:0]            scratch,
    output credit_set_t                 core_cap,
    output credit_set_t                 rem_cap
);

    logic [31:0] int_pulse;
    logic        msi_mode;

    // --------------------------------------------------
    // Interrupt status and pulse
    // --------------------------------------------------

    // Set wins over clear within a lane
    always_ff @(posedge reg_clk or negedge reg_rst_n)
    begin
        if (!reg_rst_n)
        begin
            int_status <= 32'h0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wr_strobe.int_set[i])
                    int_status[8*i +: 8] <= int_status[8*i +: 8] | wr_data[8*i +: 8];
                else if (wr_strobe.int_clr[i])
                    int_status[8*i +: 8] <= int_status[8*i +: 8] & ~wr_data[8*i +: 8];
            end
        end
    end

    // One cycle of the bits just set
    always_ff @(posedge reg_clk or negedge reg_rst_n)
    begin
        if (!reg_rst_n)
        begin
            int_pulse <= 32'h0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                int_pulse[8*i +: 8] <= {8{wr_strobe.int_set[i]}} & wr_data[8*i +: 8];
            end
        end
    end

    // MSI or MSI-X gets events, legacy gets levels
    always_ff @(posedge reg_clk or negedge reg_rst_n)
    begin
        if (!reg_rst_n)
        begin
            msi_mode       <= 1'b0;
            mgmt_interrupt <= 32'h0;
        end
        else
        begin
            msi_mode       <= msi_en | msix_en;
            mgmt_interrupt <= msi_mode ? int_pulse : int_status;
        end
    end

    // --------------------------------------------------
    // Scratch-pad registers
    // --------------------------------------------------

    // Lanes 3:0 go to the even word, lanes 7:4 to the odd word
    always_ff @(posedge reg_clk or negedge reg_rst_n)
    begin
        if (!reg_rst_n)
        begin
            scratch[0] <= `SCRATCH0_RST;
            scratch[1] <= `SCRATCH1_RST;
            scratch[2] <= `SCRATCH2_RST;
            scratch[3] <= `SCRATCH3_RST;
        end
        else
        begin
            for (int i = 0; i < `REG_SEL_W; i++)
            begin
                if (wr_strobe.scratch_lo[i])
                    scratch[i/4][(i%4)*8 +: 8] <= wr_data[8*i +: 8];
                if (wr_strobe.scratch_hi[i])
                    scratch[2 + i/4][(i%4)*8 +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    // Credits are quasi-static, captured every cycle
    always_ff @(posedge reg_clk or negedge reg_rst_n)
    begin
        if (!reg_rst_n)
        begin
            core_cap <= '0;
            rem_cap  <= '0;
        end
        else
        begin
            core_cap <= core_credits;
            rem_cap  <= rem_credits;
        end
    end

endmodule

`default_nettype wire

/* design/reg_result.sv */
`timescale 1ns/1ns
`default_nettype none

`include "reg_block_defs.svh"

module reg_result
    import reg_map_pkg::*;
(
    input  wire logic                   reg_clk,
    input  wire logic                   reg_rst_n,
    input  wire rd_sel_t                rd_sel,
    input  wire logic [31:0]            int_status,
    input  wire logic [3:0][31:0]       scratch,
    input  wire credit_set_t            core_cap,
    input  wire credit_set_t            rem_cap,
    output logic [`REG_DATA_W-1:0]      rd_data
);

    rd_word_u rd_word;

    // Place one credit type in its readback dword
    function automatic credit_dword_t to_dword(input credit_t c);
        credit_dword_t d;
        d         = '0;
        d.data    = c.data;
        d.hdr     = c.hdr;
        return d;
    endfunction

    // --------------------------------------------------
    // Read word assembly
    // --------------------------------------------------
    always_comb
    begin
        rd_word = '0;

        // Non-posted high, posted low
        if (rd_sel.core_pn)
        begin
            rd_word.credit.upper = to_dword(core_cap.np);
            rd_word.credit.lower = to_dword(core_cap.p);
        end
        if (rd_sel.rem_pn)
        begin
            rd_word.credit.upper = to_dword(rem_cap.np);
            rd_word.credit.lower = to_dword(rem_cap.p);
        end

        // Completion words leave the upper dword zero
        if (rd_sel.core_c)
            rd_word.credit.lower = to_dword(core_cap.cpl);
        if (rd_sel.rem_c)
            rd_word.credit.lower = to_dword(rem_cap.cpl);

        if (rd_sel.int_status)
            rd_word.dword.lower = int_status;
        if (rd_sel.scratch_lo)
        begin
            rd_word.dword.upper = scratch[1];
            rd_word.dword.lower = scratch[0];
        end
        if (rd_sel.scratch_hi)
        begin
            rd_word.dword.upper = scratch[3];
            rd_word.dword.lower = scratch[2];
        end
    end

    // Lands with ack
    always_ff @(posedge reg_clk or negedge reg_rst_n)
    begin
        if (!reg_rst_n)
            rd_data <= '0;
        else
            rd_data <= rd_word;
    end

endmodule

`default_nettype wire

/* design/reg_block_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "reg_block_defs.svh"

module reg_block_top
    import wb_bus_pkg::*;
    import reg_map_pkg::*;
(
    input  wire logic        reg_clk,
    input  wire logic        reg_rst_n,
    input  wire wb_req_t     wb_req,
    output wb_rsp_t          wb_rsp,
    input  wire credit_set_t core_credits,
    input  wire credit_set_t rem_credits,
    input  wire logic        msi_en,
    input  wire logic        msix_en,
    output logic [31:0]      mgmt_interrupt
);

    logic                   ack;
    logic [`REG_DATA_W-1:0] rd_data;
    wr_strobe_t             wr_strobe;
    rd_sel_t                rd_sel;
    logic [31:0]            int_status;
    logic [3:0][31:0]       scratch;
    credit_set_t            core_cap;
    credit_set_t            rem_cap;

    // --------------------------------------------------
    // Decode, execute, result
    // --------------------------------------------------
    reg_decode reg_decode_i (
        .reg_clk        (reg_clk),
        .reg_rst_n      (reg_rst_n),
        .wb_req         (wb_req),
        .ack            (ack),
        .wr_strobe      (wr_strobe),
        .rd_sel         (rd_sel)
    );

    reg_execute reg_execute_i (
        .reg_clk        (reg_clk),
        .reg_rst_n      (reg_rst_n),
        .wr_strobe      (wr_strobe),
        .wr_data        (wb_req.dat),
        .core_credits   (core_credits),
        .rem_credits    (rem_credits),
        .msi_en         (msi_en),
        .msix_en        (msix_en),
        .mgmt_interrupt (mgmt_interrupt),
        .int_status     (int_status),
        .scratch        (scratch),
        .core_cap       (core_cap),
        .rem_cap        (rem_cap)
    );

    reg_result reg_result_i (
        .reg_clk        (reg_clk),
        .reg_rst_n      (reg_rst_n),
        .rd_sel         (rd_sel),
        .int_status     (int_status),
        .scratch        (scratch),
        .core_cap       (core_cap),
        .rem_cap        (rem_cap),
        .rd_data        (rd_data)
    );

    assign wb_rsp = '{ack: ack, dat: rd_data};

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
    output logic reg_clk,
    output logic reg_rst_n
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;

    // 40 ns period
    initial
    begin
        reg_clk = 1'b0;
        forever #HALF_PERIOD reg_clk = ~reg_clk;
    end

    // Reset held for the first cycles
    initial
    begin
        reg_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge reg_clk);
        reg_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/reg_block_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "reg_block_defs.svh"

module reg_block_tb
    import wb_bus_pkg::*;
    import reg_map_pkg::*;
();

    // One bus access with its expected results
    typedef struct packed {
        // MSI-X enable, MSI enable
        logic [1:0]  irq_mode;
        logic        we;
        logic [12:0] adr;
        logic [7:0]  sel;
        logic [63:0] wdat;
        logic [63:0] exp_dat;
        logic [31:0] exp_irq;
    } entry_t;

    localparam int RESET_CYCLES     = 10;
    localparam int CYCLES_PER_ENTRY = 20;
    localparam int ACK_WAIT         = 8;

    localparam credit_set_t CORE_CR = '{
        p:   '{hdr: 8'h12, data: 12'h345},
        np:  '{hdr: 8'h23, data: 12'h456},
        cpl: '{hdr: 8'h34, data: 12'h567}
    };
    localparam credit_set_t REM_CR = '{
        p:   '{hdr: 8'h45, data: 12'h678},
        np:  '{hdr: 8'h56, data: 12'h789},
        cpl: '{hdr: 8'h67, data: 12'h89A}
    };

    logic        reg_clk;
    logic        reg_rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    credit_set_t core_credits;
    credit_set_t rem_credits;
    logic        msi_en;
    logic        msix_en;
    logic [31:0] mgmt_interrupt;

    entry_t      tbl[$];
    logic [31:0] lfsr_state;
    int          errors;
    logic        table_ready;

    tb_clock_gen tb_clock_gen_i (
        .reg_clk   (reg_clk),
        .reg_rst_n (reg_rst_n)
    );

    reg_block_top reg_block_top_i (
        .reg_clk        (reg_clk),
        .reg_rst_n      (reg_rst_n),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .core_credits   (core_credits),
        .rem_credits    (rem_credits),
        .msi_en         (msi_en),
        .msix_en        (msix_en),
        .mgmt_interrupt (mgmt_interrupt)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    // Right-shifting Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[0] ^ s[10] ^ s[30] ^ s[31];
        return {fb, s[31:1]};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Readback dword of one credit type
    function automatic logic [31:0] credit_word(input credit_t c);
        return {4'h0, c.data, 8'h00, c.hdr};
    endfunction

    function automatic logic [63:0] merge_lanes(input logic [63:0] old_val,
                                                input logic [63:0] new_val,
                                                input logic [7:0]  sel);
        logic [63:0] r;
        r = old_val;
        for (int i = 0; i < 8; i++)
        begin
            if (sel[i])
                r[8*i +: 8] = new_val[8*i +: 8];
        end
        return r;
    endfunction

    function automatic logic [12:0] word_adr(input logic [4:0] w);
        return `REG_BASE_ADDR | {8'h00, w};
    endfunction

    task automatic add_entry(input logic [1:0] irq_mode, input logic we,
                             input logic [12:0] adr, input logic [7:0] sel,
                             input logic [63:0] wdat, input logic [63:0] exp_dat,
                             input logic [31:0] exp_irq);
        tbl.push_back('{irq_mode, we, adr, sel, wdat, exp_dat, exp_irq});
    endtask

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    task automatic build_table();
        logic [63:0] lo;
        logic [63:0] hi;
        logic [63:0] d;
        logic [63:0] s;
        logic [12:0] a_lo;
        logic [12:0] a_hi;
        logic [12:0] a_st;
        logic [12:0] a_set;
        lo    = {`SCRATCH1_RST, `SCRATCH0_RST};
        hi    = {`SCRATCH3_RST, `SCRATCH2_RST};
        a_lo  = word_adr(`ADDR_SCRATCH_LO);
        a_hi  = word_adr(`ADDR_SCRATCH_HI);
        a_st  = word_adr(`ADDR_INT_STATUS);
        a_set = word_adr(`ADDR_INT_SET);

        // Reset values
        add_entry(2'b00, 1'b0, a_lo, 8'hFF, 64'h0, lo, 32'h0);
        add_entry(2'b00, 1'b0, a_hi, 8'hFF, 64'h0, hi, 32'h0);
        add_entry(2'b00, 1'b0, a_st, 8'hFF, 64'h0, 64'h0, 32'h0);

        // Byte-masked scratch writes
        for (int k = 0; k < 2; k++)
        begin
            draw_bits(8, s);
            draw_bits(64, d);
            lo = merge_lanes(lo, d, s[7:0]);
            add_entry(2'b00, 1'b1, a_lo, s[7:0], d, 64'h0, 32'h0);
            add_entry(2'b00, 1'b0, a_lo, 8'hFF, 64'h0, lo, 32'h0);
            draw_bits(8, s);
            draw_bits(64, d);
            hi = merge_lanes(hi, d, s[7:0]);
            add_entry(2'b00, 1'b1, a_hi, s[7:0], d, 64'h0, 32'h0);
            add_entry(2'b00, 1'b0, a_hi, 8'hFF, 64'h0, hi, 32'h0);
        end

        // Credit words
        add_entry(2'b00, 1'b0, word_adr(`ADDR_CORE_PN), 8'hFF, 64'h0,
                  {credit_word(CORE_CR.np), credit_word(CORE_CR.p)}, 32'h0);
        add_entry(2'b00, 1'b0, word_adr(`ADDR_CORE_C), 8'hFF, 64'h0,
                  {32'h0, credit_word(CORE_CR.cpl)}, 32'h0);
        add_entry(2'b00, 1'b0, word_adr(`ADDR_REM_PN), 8'hFF, 64'h0,
                  {credit_word(REM_CR.np), credit_word(REM_CR.p)}, 32'h0);
        add_entry(2'b00, 1'b0, word_adr(`ADDR_REM_C), 8'hFF, 64'h0,
                  {32'h0, credit_word(REM_CR.cpl)}, 32'h0);

        // Legacy mode, output follows status; upper lanes are ignored
        add_entry(2'b00, 1'b1, a_set, 8'hFF, 64'hFFFF_FFFF_0000_80F5, 64'h0, 32'h0000_80F5);
        add_entry(2'b00, 1'b0, a_st, 8'hFF, 64'h0, 64'h0000_80F5, 32'h0000_80F5);
        add_entry(2'b00, 1'b1, a_st, 8'h01, 64'h0000_0005, 64'h0, 32'h0000_80F0);
        add_entry(2'b00, 1'b1, a_set, 8'h04, 64'h5533_1100, 64'h0, 32'h0033_80F0);
        add_entry(2'b00, 1'b1, a_st, 8'hF2, 64'hFFFF_FFFF_0000_8000, 64'h0, 32'h0033_00F0);
        add_entry(2'b00, 1'b0, a_st, 8'hFF, 64'h0, 64'h0033_00F0, 32'h0033_00F0);

        // MSI and MSI-X modes, one pulse per set write
        add_entry(2'b01, 1'b1, a_set, 8'h03, 64'h0000_0300, 64'h0, 32'h0000_0300);
        add_entry(2'b01, 1'b0, a_st, 8'hFF, 64'h0, 64'h0033_03F0, 32'h0);
        add_entry(2'b01, 1'b1, a_set, 8'h08, 64'h8000_0000, 64'h0, 32'h8000_0000);
        add_entry(2'b10, 1'b1, a_set, 8'h01, 64'h0000_00F0, 64'h0, 32'h0000_00F0);

        // Out of range, write-only and unmapped words
        draw_bits(64, d);
        add_entry(2'b01, 1'b1, 13'h0810, 8'hFF, d, 64'h0, 32'h0);
        add_entry(2'b01, 1'b1, 13'h0011, 8'hFF, ~d, 64'h0, 32'h0);
        add_entry(2'b01, 1'b1, 13'h0008, 8'hFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0, 32'h0);
        add_entry(2'b01, 1'b0, 13'h0010, 8'hFF, 64'h0, 64'h0, 32'h0);
        add_entry(2'b01, 1'b0, 13'h0811, 8'hFF, 64'h0, 64'h0, 32'h0);
        add_entry(2'b01, 1'b0, a_set, 8'hFF, 64'h0, 64'h0, 32'h0);
        add_entry(2'b01, 1'b0, word_adr(5'h1F), 8'hFF, 64'h0, 64'h0, 32'h0);
        add_entry(2'b01, 1'b0, a_st, 8'hFF, 64'h0, 64'h8033_03F0, 32'h0);
        add_entry(2'b01, 1'b0, a_lo, 8'hFF, 64'h0, lo, 32'h0);
        add_entry(2'b01, 1'b0, a_hi, 8'hFF, 64'h0, hi, 32'h0);
    endtask

    // --------------------------------------------------
    // Wishbone access and checks
    // --------------------------------------------------
    task automatic run_entry(input int idx);
        entry_t      e;
        int          waited;
        logic [31:0] irq_after;
        e      = tbl[idx];
        waited = 0;

        @(posedge reg_clk);
        msi_en     <= e.irq_mode[0];
        msix_en    <= e.irq_mode[1];
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= e.we;
        wb_req.adr <= e.adr;
        wb_req.sel <= e.sel;
        wb_req.dat <= e.wdat;

        @(negedge reg_clk);
        while (wb_rsp.ack !== 1'b1 && waited < ACK_WAIT)
        begin
            waited++;
            @(negedge reg_clk);
        end

        if (wb_rsp.ack !== 1'b1)
        begin
            $display("Entry %0d: no ack within %0d cycles", idx, ACK_WAIT);
            errors++;
        end
        else
        begin
            if (waited != 1)
            begin
                $display("Entry %0d: ack came after %0d cycles instead of 1", idx, waited);
                errors++;
            end
            if (wb_rsp.dat !== e.exp_dat)
            begin
                $display("MISMATCH entry %0d wb_rsp.dat: got %h expected %h",
                         idx, wb_rsp.dat, e.exp_dat);
                errors++;
            end
        end

        @(posedge reg_clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;

        // Two edges after the sampled write
        @(negedge reg_clk);
        if (wb_rsp.ack !== 1'b0)
        begin
            $display("Entry %0d: ack stayed high for more than one cycle", idx);
            errors++;
        end
        if (mgmt_interrupt !== e.exp_irq)
        begin
            $display("MISMATCH entry %0d mgmt_interrupt: got %h expected %h",
                     idx, mgmt_interrupt, e.exp_irq);
            errors++;
        end

        // A pulse is gone one cycle later, a level stays
        @(negedge reg_clk);
        irq_after = (e.irq_mode != 2'b00) ? 32'h0 : e.exp_irq;
        if (mgmt_interrupt !== irq_after)
        begin
            $display("MISMATCH entry %0d mgmt_interrupt after: got %h expected %h",
                     idx, mgmt_interrupt, irq_after);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        errors       = 0;
        table_ready  = 1'b0;
        lfsr_state   = 32'd66847;
        wb_req       <= '0;
        core_credits <= CORE_CR;
        rem_credits  <= REM_CR;
        msi_en       <= 1'b0;
        msix_en      <= 1'b0;

        build_table();
        table_ready = 1'b1;

        wait (reg_rst_n === 1'b1);
        @(negedge reg_clk);
        if (wb_rsp !== '0)
        begin
            $display("MISMATCH after reset wb_rsp: got %h expected %h", wb_rsp, 65'h0);
            errors++;
        end
        if (mgmt_interrupt !== 32'h0)
        begin
            $display("MISMATCH after reset mgmt_interrupt: got %h expected %h",
                     mgmt_interrupt, 32'h0);
            errors++;
        end

        for (int i = 0; i < tbl.size(); i++)
            run_entry(i);

        $display("Ran %0d table entries, %0d errors", tbl.size(), errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog sized from the table length
    initial
    begin
        wait (table_ready === 1'b1);
        repeat (RESET_CYCLES + tbl.size() * CYCLES_PER_ENTRY) @(posedge reg_clk);
        $display("Timeout: the table did not complete in time, %0d errors so far", errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/wb_bus_pkg.sv
design/reg_map_pkg.sv
design/reg_decode.sv
design/reg_execute.sv
design/reg_result.sv
design/reg_block_top.sv
testbench/tb_clock_gen.sv
testbench/reg_block_tb.sv

/* Makefile */
# Verilator simulation of the register block

VERILATOR ?= verilator
TOP       ?= reg_block_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
